/* build.f */
rtl/mem_pkg.sv
rtl/mem_req_reg.sv
rtl/dtlb_lookup.sv
rtl/mem_xlate_check.sv
rtl/mem_wb_reg.sv
rtl/mem_stage_top.sv
sim/tb_mem_stage.sv

/* Makefile */
TOP := tb_mem_stage
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): build.f rtl/*.sv sim/*.sv
	verilator --binary --timing --assert -f build.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module $(TOP)
	verilator --lint-only -Wall rtl/mem_pkg.sv rtl/mem_req_reg.sv rtl/dtlb_lookup.sv \
		rtl/mem_xlate_check.sv rtl/mem_wb_reg.sv rtl/mem_stage_top.sv \
		--top-module mem_stage_top

clean:
	rm -rf obj_dir $(LOG)

/* sim/tb_mem_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

    localparam int N_INSTR = 400;
    localparam int LIMIT   = 4 * N_INSTR + 200;

    logic clk;
    logic rst_n_i;
    logic stall_i;
    logic flush_i;
    logic ex_valid_i;
    logic [mem_pkg::XLEN-1:0] ex_pc_i;
    mem_pkg::mem_op_t ex_op_i;
    logic [mem_pkg::XLEN-1:0] ex_vaddr_i;
    logic [mem_pkg::REG_AW-1:0] ex_waddr_i;
    logic ex_we_i;
    logic [mem_pkg::XLEN-1:0] ex_wdata_i;
    logic ex_excp_i;
    logic tlb_we_i;
    logic [mem_pkg::TLB_IDX_W-1:0] tlb_idx_i;
    logic [mem_pkg::VPPN_W-1:0] tlb_vppn_i;
    logic [mem_pkg::PPN_W-1:0] tlb_ppn_i;
    logic tlb_v_i;
    logic tlb_d_i;
    logic [1:0] tlb_plv_i;
    logic csr_da_i;
    logic csr_pg_i;
    logic [1:0] csr_plv_i;
    logic [mem_pkg::XLEN-1:0] csr_dmw0_i;
    logic [mem_pkg::XLEN-1:0] csr_dmw1_i;
    logic wb_valid_o;
    logic [mem_pkg::XLEN-1:0] wb_pc_o;
    logic [mem_pkg::REG_AW-1:0] wb_waddr_o;
    logic wb_we_o;
    logic [mem_pkg::XLEN-1:0] wb_wdata_o;
    logic [mem_pkg::XLEN-1:0] wb_paddr_o;
    logic wb_excp_o;
    logic [mem_pkg::EXCP_W-1:0] wb_excp_vec_o;
    logic wb_tlb_found_o;
    logic [mem_pkg::TLB_IDX_W-1:0] wb_tlb_idx_o;
    logic dcache_flush_o;
    logic trans_en_o;

    // model tlb
    logic t_ex [mem_pkg::TLB_ENTRIES];
    logic t_v [mem_pkg::TLB_ENTRIES];
    logic t_d [mem_pkg::TLB_ENTRIES];
    logic [1:0] t_plv [mem_pkg::TLB_ENTRIES];
    logic [mem_pkg::VPPN_W-1:0] t_vppn [mem_pkg::TLB_ENTRIES];
    logic [mem_pkg::PPN_W-1:0] t_ppn [mem_pkg::TLB_ENTRIES];

    // model memory stage
    logic mv, mwe, mex;
    mem_pkg::mem_op_t mop;
    logic [mem_pkg::XLEN-1:0] mpc, mva, mwd;
    logic [mem_pkg::REG_AW-1:0] mwa;

    // model writeback stage
    logic ev, ewe, eexc, efound;
    logic [mem_pkg::XLEN-1:0] epc, ewd, epa;
    logic [mem_pkg::REG_AW-1:0] ewa;
    logic [mem_pkg::EXCP_W-1:0] evec;
    logic [mem_pkg::TLB_IDX_W-1:0] eidx;

    // pcs accepted and not yet retired, oldest first
    logic [mem_pkg::XLEN-1:0] accepted [$];

    int cycles;
    int retired;
    int issued;
    int phase;

    mem_stage_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_fail(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    function automatic logic window_hit(input logic [mem_pkg::XLEN-1:0] dmw,
                                        input logic [1:0] plv,
                                        input logic [2:0] vtop);
        logic plv_ok;
        plv_ok = (plv == 2'd0 && dmw[0]) || (plv == 2'd3 && dmw[3]);
        return plv_ok && dmw[31:29] == vtop;
    endfunction

    // predicted translation of the model memory stage
    function automatic void predict(output logic te, output logic [31:0] pa,
                                    output logic [5:0] vec, output logic any,
                                    output logic found, output logic [2:0] idx);
        logic h0, h1, hit, over, ld, st;
        h0 = window_hit(csr_dmw0_i, csr_plv_i, mva[31:29]);
        h1 = window_hit(csr_dmw1_i, csr_plv_i, mva[31:29]);
        ld = mop == mem_pkg::MEM_LOAD;
        st = mop == mem_pkg::MEM_STORE;
        te = (ld || st) && mv && csr_pg_i && !csr_da_i && !h0 && !h1;
        found = 1'b0;
        idx = '0;
        for (int i = mem_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            if (t_ex[i] && t_vppn[i] == mva[31:12]) begin
                found = 1'b1;
                idx = 3'(i);
            end
        end
        if (te) pa = {found ? t_ppn[idx] : 20'd0, mva[11:0]};
        else if (h0) pa = {csr_dmw0_i[27:25], mva[28:0]};
        else if (h1) pa = {csr_dmw1_i[27:25], mva[28:0]};
        else pa = mva;
        hit = te && found;
        over = csr_plv_i > t_plv[idx];
        vec = '0;
        vec[mem_pkg::EXCP_UP] = mex;
        vec[mem_pkg::EXCP_TLBR] = te && !found;
        vec[mem_pkg::EXCP_PIL] = hit && ld && !t_v[idx];
        vec[mem_pkg::EXCP_PIS] = hit && st && !t_v[idx];
        vec[mem_pkg::EXCP_PPI] = hit && t_v[idx] && over;
        vec[mem_pkg::EXCP_PME] = hit && st && t_v[idx] && !over && !t_d[idx];
        any = mv && (|vec);
    endfunction

    task automatic check_wb(input logic valid, input logic [mem_pkg::XLEN-1:0] pc,
                            input logic [mem_pkg::REG_AW-1:0] wa, input logic we,
                            input logic [mem_pkg::XLEN-1:0] wd,
                            input logic [mem_pkg::XLEN-1:0] pa);
        if (wb_valid_o !== valid || wb_we_o !== we)
            report_fail($sformatf("wb valid/we %b%b, expected %b%b",
                                  wb_valid_o, wb_we_o, valid, we));
        if (valid && (wb_pc_o !== pc || wb_waddr_o !== wa || wb_wdata_o !== wd))
            report_fail($sformatf("wb pc %h, expected %h", wb_pc_o, pc));
        if (valid && wb_paddr_o !== pa)
            report_fail($sformatf("wb paddr %h, expected %h", wb_paddr_o, pa));
    endtask

    task automatic check_excp(input logic excp, input logic [mem_pkg::EXCP_W-1:0] vec,
                              input logic found, input logic [mem_pkg::TLB_IDX_W-1:0] idx);
        if (wb_excp_o !== excp || wb_excp_vec_o !== vec)
            report_fail($sformatf("excp %b vec %b, expected %b %b",
                                  wb_excp_o, wb_excp_vec_o, excp, vec));
        if (wb_tlb_found_o !== found || (found && wb_tlb_idx_o !== idx))
            report_fail($sformatf("tlb found %b idx %0d, expected %b %0d",
                                  wb_tlb_found_o, wb_tlb_idx_o, found, idx));
    endtask

    task automatic check_side(input logic flush, input logic te);
        if (dcache_flush_o !== flush || trans_en_o !== te)
            report_fail($sformatf("dcache_flush %b trans_en %b, expected %b %b",
                                  dcache_flush_o, trans_en_o, flush, te));
    endtask

    // reference model stepped on the same edge as the DUT
    always @(posedge clk) begin
        logic te, any, found;
        logic [31:0] pa;
        logic [5:0] vec;
        logic [2:0] idx;
        cycles++;
        if (cycles > LIMIT) begin
            $display("timeout: run exceeded %0d cycles", LIMIT);
            $display("TESTS FAILED");
            $fatal(1);
        end
        predict(te, pa, vec, any, found, idx);
        if (!rst_n_i || flush_i || stall_i) begin
            ev = 0;
            ewe = 0;
            eexc = 0;
            evec = '0;
            efound = 0;
        end else begin
            ev = mv;
            ewe = mv && mwe;
            eexc = any;
            evec = vec;
            efound = found;
        end
        if (!stall_i) begin
            epc = mpc;
            ewa = mwa;
            ewd = mwd;
            epa = pa;
            eidx = idx;
        end
        if (!rst_n_i || flush_i) begin
            mv = 0;
            mop = mem_pkg::MEM_NONE;
            mwe = 0;
            mex = 0;
            accepted.delete();
        end else if (!stall_i) begin
            mv = ex_valid_i;
            mop = ex_valid_i ? ex_op_i : mem_pkg::MEM_NONE;
            mwe = ex_valid_i && ex_we_i;
            mex = ex_valid_i && ex_excp_i;
            if (ex_valid_i) accepted.push_back(ex_pc_i);
        end
        // payload follows the input whenever the stage is not held
        if (!stall_i) begin
            mpc = ex_pc_i;
            mva = ex_vaddr_i;
            mwa = ex_waddr_i;
            mwd = ex_wdata_i;
        end
        if (!rst_n_i) begin
            for (int i = 0; i < mem_pkg::TLB_ENTRIES; i++) t_ex[i] = 0;
        end else if (tlb_we_i) begin
            t_ex[tlb_idx_i] = 1;
            t_v[tlb_idx_i] = tlb_v_i;
            t_d[tlb_idx_i] = tlb_d_i;
            t_plv[tlb_idx_i] = tlb_plv_i;
            t_vppn[tlb_idx_i] = tlb_vppn_i;
            t_ppn[tlb_idx_i] = tlb_ppn_i;
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        logic te, any, found;
        logic [31:0] pa;
        logic [5:0] vec;
        logic [2:0] idx;
        logic [mem_pkg::XLEN-1:0] exp_pc;
        if (rst_n_i) begin
            predict(te, pa, vec, any, found, idx);
            check_wb(ev, epc, ewa, ewe, ewd, epa);
            check_excp(eexc, evec, efound, eidx);
            check_side(any, te);
            // retire order against the accepted stream
            if (wb_valid_o) begin
                retired++;
                if (accepted.size() == 0) begin
                    report_fail("an instruction retired that was never accepted");
                end else begin
                    exp_pc = accepted.pop_front();
                    if (wb_pc_o !== exp_pc)
                        report_fail($sformatf("retired pc %h, expected %h", wb_pc_o, exp_pc));
                end
            end
        end
    end

    initial begin
        void'($urandom(32'h6fda479a));
        cycles = 0;
        retired = 0;
        issued = 0;
        rst_n_i = 0;
        stall_i = 0;
        flush_i = 0;
        ex_valid_i = 0;
        ex_pc_i = '0;
        ex_op_i = mem_pkg::MEM_NONE;
        ex_vaddr_i = '0;
        ex_waddr_i = '0;
        ex_we_i = 0;
        ex_wdata_i = '0;
        ex_excp_i = 0;
        tlb_we_i = 0;
        tlb_idx_i = '0;
        tlb_vppn_i = '0;
        tlb_ppn_i = '0;
        tlb_v_i = 0;
        tlb_d_i = 0;
        tlb_plv_i = '0;
        csr_da_i = 1;
        csr_pg_i = 0;
        csr_plv_i = '0;
        csr_dmw0_i = '0;
        csr_dmw1_i = '0;
        repeat (3) @(posedge clk);
        rst_n_i <= 1;
        // duplicate page numbers exercise lowest-index priority
        for (int i = 0; i < mem_pkg::TLB_ENTRIES; i++) begin
            @(posedge clk);
            tlb_we_i <= 1;
            tlb_idx_i <= 3'(i);
            tlb_vppn_i <= 20'h00040 + 20'($urandom % 6);
            tlb_ppn_i <= 20'($urandom);
            tlb_v_i <= ($urandom % 4) != 0;
            tlb_d_i <= 1'($urandom);
            tlb_plv_i <= 2'($urandom);
        end
        while (issued < N_INSTR) begin
            @(posedge clk);
            tlb_we_i <= 0;
            phase = issued / 80;
            if (!stall_i) begin
                issued++;
                csr_da_i <= phase == 0;
                csr_pg_i <= phase != 0;
                csr_plv_i <= 2'($urandom);
                csr_dmw0_i <= phase == 1 ? $urandom & 32'hee00_0009 : '0;
                csr_dmw1_i <= phase == 1 ? $urandom & 32'hee00_0009 : '0;
                ex_valid_i <= ($urandom % 8) != 0;
                ex_pc_i <= 32'h1c00_0000 + 32'(issued * 4);
                ex_op_i <= mem_pkg::mem_op_t'($urandom % 3);
                if ($urandom % 2)
                    ex_vaddr_i <= {3'($urandom), 9'd0, 8'h40 + 8'($urandom % 10), 12'($urandom)};
                else
                    ex_vaddr_i <= {12'd0, 8'h40 + 8'($urandom % 10), 12'($urandom)};
                ex_waddr_i <= 5'($urandom);
                ex_we_i <= 1'($urandom);
                ex_wdata_i <= $urandom;
                ex_excp_i <= ($urandom % 8) == 0;
            end
            stall_i <= phase >= 3 && ($urandom % 4) == 0;
            flush_i <= phase >= 4 && ($urandom % 10) == 0;
        end
        @(posedge clk);
        ex_valid_i <= 0;
        stall_i <= 0;
        flush_i <= 0;
        repeat (4) @(posedge clk);
        if (accepted.size() != 0 || retired == 0) begin
            $display("%0d accepted instructions never retired, %0d retired in total",
                     accepted.size(), retired);
            $display("TESTS FAILED");
            $fatal(1);
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* rtl/mem_stage_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top (
    input  wire                              clk,
    input  wire                              rst_n_i,
    input  wire                              stall_i,
    input  wire                              flush_i,
    input  wire                              ex_valid_i,
    input  wire  [mem_pkg::XLEN-1:0]         ex_pc_i,
    input  wire  mem_pkg::mem_op_t           ex_op_i,
    input  wire  [mem_pkg::XLEN-1:0]         ex_vaddr_i,
    input  wire  [mem_pkg::REG_AW-1:0]       ex_waddr_i,
    input  wire                              ex_we_i,
    input  wire  [mem_pkg::XLEN-1:0]         ex_wdata_i,
    input  wire                              ex_excp_i,
    input  wire                              tlb_we_i,
    input  wire  [mem_pkg::TLB_IDX_W-1:0]    tlb_idx_i,
    input  wire  [mem_pkg::VPPN_W-1:0]       tlb_vppn_i,
    input  wire  [mem_pkg::PPN_W-1:0]        tlb_ppn_i,
    input  wire                              tlb_v_i,
    input  wire                              tlb_d_i,
    input  wire  [1:0]                       tlb_plv_i,
    input  wire                              csr_da_i,
    input  wire                              csr_pg_i,
    input  wire  [1:0]                       csr_plv_i,
    input  wire  [mem_pkg::XLEN-1:0]         csr_dmw0_i,
    input  wire  [mem_pkg::XLEN-1:0]         csr_dmw1_i,
    output logic                             wb_valid_o,
    output logic [mem_pkg::XLEN-1:0]         wb_pc_o,
    output logic [mem_pkg::REG_AW-1:0]       wb_waddr_o,
    output logic                             wb_we_o,
    output logic [mem_pkg::XLEN-1:0]         wb_wdata_o,
    output logic [mem_pkg::XLEN-1:0]         wb_paddr_o,
    output logic                             wb_excp_o,
    output logic [mem_pkg::EXCP_W-1:0]       wb_excp_vec_o,
    output logic                             wb_tlb_found_o,
    output logic [mem_pkg::TLB_IDX_W-1:0]    wb_tlb_idx_o,
    output logic                             dcache_flush_o,
    output logic                             trans_en_o
);

    // memory-stage request
    logic                          m_valid;
    logic [mem_pkg::XLEN-1:0]      m_pc;
    mem_pkg::mem_op_t              m_op;
    logic [mem_pkg::XLEN-1:0]      m_vaddr;
    logic [mem_pkg::REG_AW-1:0]    m_waddr;
    logic                          m_we;
    logic [mem_pkg::XLEN-1:0]      m_wdata;
    logic                          m_excp;

    // tlb lookup result
    logic                          lk_found;
    logic                          lk_v;
    logic                          lk_d;
    logic [1:0]                    lk_plv;
    logic [mem_pkg::PPN_W-1:0]     lk_ppn;
    logic [mem_pkg::TLB_IDX_W-1:0] lk_idx;

    logic [mem_pkg::XLEN-1:0]      paddr;
    logic [mem_pkg::EXCP_W-1:0]    excp_vec;

    mem_req_reg u_req (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .ex_valid_i (ex_valid_i),
        .ex_pc_i    (ex_pc_i),
        .ex_op_i    (ex_op_i),
        .ex_vaddr_i (ex_vaddr_i),
        .ex_waddr_i (ex_waddr_i),
        .ex_we_i    (ex_we_i),
        .ex_wdata_i (ex_wdata_i),
        .ex_excp_i  (ex_excp_i),
        .m_valid_o  (m_valid),
        .m_pc_o     (m_pc),
        .m_op_o     (m_op),
        .m_vaddr_o  (m_vaddr),
        .m_waddr_o  (m_waddr),
        .m_we_o     (m_we),
        .m_wdata_o  (m_wdata),
        .m_excp_o   (m_excp)
    );

    dtlb_lookup u_tlb (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .tlb_we_i      (tlb_we_i),
        .tlb_idx_i     (tlb_idx_i),
        .tlb_vppn_i    (tlb_vppn_i),
        .tlb_ppn_i     (tlb_ppn_i),
        .tlb_v_i       (tlb_v_i),
        .tlb_d_i       (tlb_d_i),
        .tlb_plv_i     (tlb_plv_i),
        .lookup_vppn_i (m_vaddr[mem_pkg::XLEN-1 -: mem_pkg::VPPN_W]),
        .found_o       (lk_found),
        .v_o           (lk_v),
        .d_o           (lk_d),
        .plv_o         (lk_plv),
        .ppn_o         (lk_ppn),
        .idx_o         (lk_idx)
    );

    mem_xlate_check u_xlate (
        .m_valid_i   (m_valid),
        .m_op_i      (m_op),
        .m_vaddr_i   (m_vaddr),
        .m_excp_i    (m_excp),
        .csr_da_i    (csr_da_i),
        .csr_pg_i    (csr_pg_i),
        .csr_plv_i   (csr_plv_i),
        .csr_dmw0_i  (csr_dmw0_i),
        .csr_dmw1_i  (csr_dmw1_i),
        .tlb_found_i (lk_found),
        .tlb_v_i     (lk_v),
        .tlb_d_i     (lk_d),
        .tlb_plv_i   (lk_plv),
        .tlb_ppn_i   (lk_ppn),
        .trans_en_o  (trans_en_o),
        .paddr_o     (paddr),
        .excp_vec_o  (excp_vec),
        .excp_any_o  (dcache_flush_o)
    );

    mem_wb_reg u_wb (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall_i),
        .flush_i        (flush_i),
        .m_valid_i      (m_valid),
        .m_pc_i         (m_pc),
        .m_waddr_i      (m_waddr),
        .m_we_i         (m_we),
        .m_wdata_i      (m_wdata),
        .paddr_i        (paddr),
        .excp_vec_i     (excp_vec),
        .excp_any_i     (dcache_flush_o),
        .tlb_found_i    (lk_found),
        .tlb_idx_i      (lk_idx),
        .wb_valid_o     (wb_valid_o),
        .wb_pc_o        (wb_pc_o),
        .wb_waddr_o     (wb_waddr_o),
        .wb_we_o        (wb_we_o),
        .wb_wdata_o     (wb_wdata_o),
        .wb_paddr_o     (wb_paddr_o),
        .wb_excp_o      (wb_excp_o),
        .wb_excp_vec_o  (wb_excp_vec_o),
        .wb_tlb_found_o (wb_tlb_found_o),
        .wb_tlb_idx_o   (wb_tlb_idx_o)
    );

endmodule

`default_nettype wire

/* rtl/mem_wb_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg (
    input  wire                              clk,
    input  wire                              rst_n_i,
    input  wire                              stall_i,
    input  wire                              flush_i,
    input  wire                              m_valid_i,
    input  wire  [mem_pkg::XLEN-1:0]         m_pc_i,
    input  wire  [mem_pkg::REG_AW-1:0]       m_waddr_i,
    input  wire                              m_we_i,
    input  wire  [mem_pkg::XLEN-1:0]         m_wdata_i,
    input  wire  [mem_pkg::XLEN-1:0]         paddr_i,
    input  wire  [mem_pkg::EXCP_W-1:0]       excp_vec_i,
    input  wire                              excp_any_i,
    input  wire                              tlb_found_i,
    input  wire  [mem_pkg::TLB_IDX_W-1:0]    tlb_idx_i,
    output logic                             wb_valid_o,
    output logic [mem_pkg::XLEN-1:0]         wb_pc_o,
    output logic [mem_pkg::REG_AW-1:0]       wb_waddr_o,
    output logic                             wb_we_o,
    output logic [mem_pkg::XLEN-1:0]         wb_wdata_o,
    output logic [mem_pkg::XLEN-1:0]         wb_paddr_o,
    output logic                             wb_excp_o,
    output logic [mem_pkg::EXCP_W-1:0]       wb_excp_vec_o,
    output logic                             wb_tlb_found_o,
    output logic [mem_pkg::TLB_IDX_W-1:0]    wb_tlb_idx_o
);

    // a stall inserts a bubble, same as a flush
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i || stall_i) begin
            wb_valid_o     <= 1'b0;
            wb_we_o        <= 1'b0;
            wb_excp_o      <= 1'b0;
            wb_excp_vec_o  <= '0;
            wb_tlb_found_o <= 1'b0;
        end else begin
            wb_valid_o     <= m_valid_i;
            wb_we_o        <= m_valid_i && m_we_i;
            wb_excp_o      <= excp_any_i;
            wb_excp_vec_o  <= excp_vec_i;
            wb_tlb_found_o <= tlb_found_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wb_pc_o      <= m_pc_i;
            wb_waddr_o   <= m_waddr_i;
            wb_wdata_o   <= m_wdata_i;
            wb_paddr_o   <= paddr_i;
            wb_tlb_idx_o <= tlb_idx_i;
        end
    end

    a_excp_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_excp_o |-> wb_valid_o);

endmodule

`default_nettype wire

/* rtl/mem_xlate_check.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_xlate_check (
    input  wire                            m_valid_i,
    input  wire  mem_pkg::mem_op_t         m_op_i,
    input  wire  [mem_pkg::XLEN-1:0]       m_vaddr_i,
    input  wire                            m_excp_i,
    input  wire                            csr_da_i,
    input  wire                            csr_pg_i,
    input  wire  [1:0]                     csr_plv_i,
    input  wire  [mem_pkg::XLEN-1:0]       csr_dmw0_i,
    input  wire  [mem_pkg::XLEN-1:0]       csr_dmw1_i,
    input  wire                            tlb_found_i,
    input  wire                            tlb_v_i,
    input  wire                            tlb_d_i,
    input  wire  [1:0]                     tlb_plv_i,
    input  wire  [mem_pkg::PPN_W-1:0]      tlb_ppn_i,
    output logic                           trans_en_o,
    output logic [mem_pkg::XLEN-1:0]       paddr_o,
    output logic [mem_pkg::EXCP_W-1:0]     excp_vec_o,
    output logic                           excp_any_o
);

    logic is_load;
    logic is_store;
    logic pg_mode;
    logic dmw0_hit;
    logic dmw1_hit;
    logic page_hit;
    logic plv_over;
    logic excp_tlbr;
    logic excp_pil;
    logic excp_pis;
    logic excp_ppi;
    logic excp_pme;

    function automatic logic dmw_hit(input logic [mem_pkg::XLEN-1:0] dmw,
                                     input logic [1:0] plv,
                                     input logic [mem_pkg::DMW_SEG_W-1:0] vseg);
        logic plv_ok;
        plv_ok = (dmw[mem_pkg::DMW_PLV0_BIT] && plv == 2'd0) ||
                 (dmw[mem_pkg::DMW_PLV3_BIT] && plv == 2'd3);
        return plv_ok && (dmw[mem_pkg::DMW_VSEG_LSB +: mem_pkg::DMW_SEG_W] == vseg);
    endfunction

    assign is_load  = (m_op_i == mem_pkg::MEM_LOAD);
    assign is_store = (m_op_i == mem_pkg::MEM_STORE);
    assign pg_mode  = csr_pg_i && !csr_da_i;

    assign dmw0_hit = dmw_hit(csr_dmw0_i, csr_plv_i,
                              m_vaddr_i[mem_pkg::DMW_VSEG_LSB +: mem_pkg::DMW_SEG_W]);
    assign dmw1_hit = dmw_hit(csr_dmw1_i, csr_plv_i,
                              m_vaddr_i[mem_pkg::DMW_VSEG_LSB +: mem_pkg::DMW_SEG_W]);

    assign trans_en_o = (is_load || is_store) && m_valid_i && pg_mode && !dmw0_hit && !dmw1_hit;

    always_comb begin
        if (trans_en_o) begin
            paddr_o = {tlb_ppn_i, m_vaddr_i[mem_pkg::XLEN-mem_pkg::PPN_W-1:0]};
        end else if (dmw0_hit) begin
            paddr_o = {csr_dmw0_i[mem_pkg::DMW_PSEG_LSB +: mem_pkg::DMW_SEG_W],
                       m_vaddr_i[mem_pkg::DMW_VSEG_LSB-1:0]};
        end else if (dmw1_hit) begin
            paddr_o = {csr_dmw1_i[mem_pkg::DMW_PSEG_LSB +: mem_pkg::DMW_SEG_W],
                       m_vaddr_i[mem_pkg::DMW_VSEG_LSB-1:0]};
        end else begin
            paddr_o = m_vaddr_i;
        end
    end

    // page faults only apply to an entry that matched
    assign page_hit  = trans_en_o && tlb_found_i;
    assign plv_over  = csr_plv_i > tlb_plv_i;
    assign excp_tlbr = trans_en_o && !tlb_found_i;
    assign excp_pil  = page_hit && is_load && !tlb_v_i;
    assign excp_pis  = page_hit && is_store && !tlb_v_i;
    assign excp_ppi  = page_hit && tlb_v_i && plv_over;
    assign excp_pme  = page_hit && is_store && tlb_v_i && !plv_over && !tlb_d_i;

    always_comb begin
        excp_vec_o                     = '0;
        excp_vec_o[mem_pkg::EXCP_UP]   = m_excp_i;
        excp_vec_o[mem_pkg::EXCP_TLBR] = excp_tlbr;
        excp_vec_o[mem_pkg::EXCP_PIL]  = excp_pil;
        excp_vec_o[mem_pkg::EXCP_PIS]  = excp_pis;
        excp_vec_o[mem_pkg::EXCP_PPI]  = excp_ppi;
        excp_vec_o[mem_pkg::EXCP_PME]  = excp_pme;
    end

    assign excp_any_o = m_valid_i && (|excp_vec_o);

endmodule

`default_nettype wire

/* rtl/dtlb_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module dtlb_lookup (
    input  wire                              clk,
    input  wire                              rst_n_i,
    input  wire                              tlb_we_i,
    input  wire  [mem_pkg::TLB_IDX_W-1:0]    tlb_idx_i,
    input  wire  [mem_pkg::VPPN_W-1:0]       tlb_vppn_i,
    input  wire  [mem_pkg::PPN_W-1:0]        tlb_ppn_i,
    input  wire                              tlb_v_i,
    input  wire                              tlb_d_i,
    input  wire  [1:0]                       tlb_plv_i,
    input  wire  [mem_pkg::VPPN_W-1:0]       lookup_vppn_i,
    output logic                             found_o,
    output logic                             v_o,
    output logic                             d_o,
    output logic [1:0]                       plv_o,
    output logic [mem_pkg::PPN_W-1:0]        ppn_o,
    output logic [mem_pkg::TLB_IDX_W-1:0]    idx_o
);

    logic [mem_pkg::TLB_ENTRIES-1:0] ent_exists;
    logic [mem_pkg::TLB_ENTRIES-1:0] ent_v;
    logic [mem_pkg::TLB_ENTRIES-1:0] ent_d;
    logic [1:0]                      ent_plv  [mem_pkg::TLB_ENTRIES];
    logic [mem_pkg::VPPN_W-1:0]      ent_vppn [mem_pkg::TLB_ENTRIES];
    logic [mem_pkg::PPN_W-1:0]       ent_ppn  [mem_pkg::TLB_ENTRIES];
    logic [mem_pkg::TLB_ENTRIES-1:0] hit;

    // an entry written with v low still exists
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ent_exists <= '0;
        end else if (tlb_we_i) begin
            ent_exists[tlb_idx_i] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we_i) begin
            ent_v[tlb_idx_i]    <= tlb_v_i;
            ent_d[tlb_idx_i]    <= tlb_d_i;
            ent_plv[tlb_idx_i]  <= tlb_plv_i;
            ent_vppn[tlb_idx_i] <= tlb_vppn_i;
            ent_ppn[tlb_idx_i]  <= tlb_ppn_i;
        end
    end

    always_comb begin
        for (int i = 0; i < mem_pkg::TLB_ENTRIES; i++) begin
            hit[i] = ent_exists[i] && (ent_vppn[i] == lookup_vppn_i);
        end
    end

    // scan downward so the lowest matching index is kept
    always_comb begin
        found_o = 1'b0;
        idx_o   = '0;
        for (int i = mem_pkg::TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                found_o = 1'b1;
                idx_o   = mem_pkg::TLB_IDX_W'(i);
            end
        end
    end

    assign v_o   = found_o && ent_v[idx_o];
    assign d_o   = found_o && ent_d[idx_o];
    assign plv_o = found_o ? ent_plv[idx_o] : 2'd0;
    assign ppn_o = found_o ? ent_ppn[idx_o] : '0;

    a_we_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        tlb_we_i |-> !$isunknown({tlb_idx_i, tlb_vppn_i}));

endmodule

`default_nettype wire

/* rtl/mem_req_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_req_reg (
    input  wire                            clk,
    input  wire                            rst_n_i,
    input  wire                            stall_i,
    input  wire                            flush_i,
    input  wire                            ex_valid_i,
    input  wire  [mem_pkg::XLEN-1:0]       ex_pc_i,
    input  wire  mem_pkg::mem_op_t         ex_op_i,
    input  wire  [mem_pkg::XLEN-1:0]       ex_vaddr_i,
    input  wire  [mem_pkg::REG_AW-1:0]     ex_waddr_i,
    input  wire                            ex_we_i,
    input  wire  [mem_pkg::XLEN-1:0]       ex_wdata_i,
    input  wire                            ex_excp_i,
    output logic                           m_valid_o,
    output logic [mem_pkg::XLEN-1:0]       m_pc_o,
    output mem_pkg::mem_op_t               m_op_o,
    output logic [mem_pkg::XLEN-1:0]       m_vaddr_o,
    output logic [mem_pkg::REG_AW-1:0]     m_waddr_o,
    output logic                           m_we_o,
    output logic [mem_pkg::XLEN-1:0]       m_wdata_o,
    output logic                           m_excp_o
);

    // flush wins over stall
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            m_valid_o <= 1'b0;
            m_op_o    <= mem_pkg::MEM_NONE;
            m_we_o    <= 1'b0;
            m_excp_o  <= 1'b0;
        end else if (!stall_i) begin
            m_valid_o <= ex_valid_i;
            m_op_o    <= ex_valid_i ? ex_op_i : mem_pkg::MEM_NONE;
            m_we_o    <= ex_valid_i && ex_we_i;
            m_excp_o  <= ex_valid_i && ex_excp_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            m_pc_o    <= ex_pc_i;
            m_vaddr_o <= ex_vaddr_i;
            m_waddr_o <= ex_waddr_i;
            m_wdata_o <= ex_wdata_i;
        end
    end

    a_op_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
        m_valid_o |-> (m_op_o inside {mem_pkg::MEM_NONE, mem_pkg::MEM_LOAD, mem_pkg::MEM_STORE}));

endmodule

`default_nettype wire

/* rtl/mem_pkg.sv */
`default_nettype none

package mem_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // 4 KB pages
    localparam int VPPN_W = 20;
    localparam int PPN_W  = 20;

    localparam int TLB_ENTRIES = 8;
    localparam int TLB_IDX_W   = 3;

    // ll counts as load, sc as store
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_t;

    // exception vector bits
    localparam int EXCP_W    = 6;
    localparam int EXCP_UP   = 0;
    localparam int EXCP_TLBR = 1;
    localparam int EXCP_PIL  = 2;
    localparam int EXCP_PIS  = 3;
    localparam int EXCP_PPI  = 4;
    localparam int EXCP_PME  = 5;

    // dmw csr fields
    localparam int DMW_PLV0_BIT = 0;
    localparam int DMW_PLV3_BIT = 3;
    localparam int DMW_PSEG_LSB = 25;
    localparam int DMW_VSEG_LSB = 29;
    localparam int DMW_SEG_W    = 3;

endpackage

`default_nettype wire
